// File: tb.f
rtl/rv32i_pkg.sv
rtl/rv32i_decoder.sv
rtl/rv32i_imm_gen.sv
rtl/rv32i_decode_stage.sv
rtl/rv32i_decode_top.sv
bench/tb_decode_top.sv

// File: Makefile
TOP := tb_decode_top

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module rv32i_decode_top \
		rtl/rv32i_pkg.sv rtl/rv32i_decoder.sv rtl/rv32i_imm_gen.sv \
		rtl/rv32i_decode_stage.sv rtl/rv32i_decode_top.sv
	verilator --lint-only --timing --top-module $(TOP) -f tb.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f \
		--Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "CHECKS FAILED" sim.log; then echo "Simulation reported failure"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" sim.log || { echo "Simulation did not complete"; exit 1; }

clean:
	rm -rf obj_dir sim.log

// File: bench/tb_decode_top.sv
`timescale 1ns/1ps

module tb_decode_top;

    import rv32i_pkg::*;

    localparam int TIMEOUT = 50;  // Cycles per wait loop

    logic                clk_i = 1'b0;
    logic                arst_n_i;
    logic                req_i;
    logic                ack_o;
    logic [31:0]         pc_i;
    logic [31:0]         instr_i;
    logic                out_req_o;
    logic                out_ack_i;
    logic [CW_WIDTH-1:0] ctrl_o;
    logic [2:0]          branch_sel_o;
    logic [31:0]         imm_o;
    logic                illegal_o;
    logic [31:0]         link_o;
    logic [31:0]         target_o;
    logic [31:0]         trace_pc_o;
    logic [31:0]         trace_instr_o;

    string cur_test;
    int    checks = 0;
    int    errors = 0;
    int    test_base = 0;  // Error count when the current test began

    rv32i_decode_top DUT (.*);

    always #10 clk_i = ~clk_i;

    function automatic logic [4:0] rnd_reg();
        return 5'($urandom);
    endfunction

    function automatic logic [31:0] rnd_pc();
        return $urandom & 32'hffff_fffc;  // Word aligned
    endfunction

    function automatic logic [31:0] sext(logic [31:0] v, int bits);
        if (v[bits-1])
            return v | ~((32'd1 << bits) - 32'd1);
        return v;
    endfunction

    // Encoders place a known immediate into the instruction layout
    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3);
        return {f7, rnd_reg(), rnd_reg(), f3, rnd_reg(), OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [2:0] f3, logic [6:0] opc);
        return {imm, rnd_reg(), f3, rnd_reg(), opc};
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] imm, logic [2:0] f3);
        return {imm[11:5], rnd_reg(), rnd_reg(), f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] imm, logic [2:0] f3);
        return {imm[12], imm[10:5], rnd_reg(), rnd_reg(), f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rnd_reg(), OPC_JAL};
    endfunction

    function automatic logic [3:0] alu_fn(logic [2:0] f3, logic alt, logic is_reg);
        case (f3)
            3'd0:    return (alt && is_reg) ? FN_SUB : FN_ADD;
            3'd1:    return FN_SLL;
            3'd2:    return FN_SLT;
            3'd3:    return FN_SLTU;
            3'd4:    return FN_XOR;
            3'd5:    return alt ? FN_SRA : FN_SRL;
            3'd6:    return FN_OR;
            default: return FN_AND;
        endcase
    endfunction

    function automatic logic [2:0] br_code(logic [2:0] f3);
        case (f3)
            3'd0:       return BR_EQ;
            3'd1:       return BR_NE;
            3'd4, 3'd6: return BR_LT;  // Signed and unsigned
            3'd5, 3'd7: return BR_GE;
            default:    return BR_NONE;
        endcase
    endfunction

    task automatic begin_test(string name);
        cur_test  = name;
        test_base = errors;
    endtask

    task automatic end_test();
        $display("test %-12s finished with %0d errors", cur_test, errors - test_base);
    endtask

    task automatic check_val(string field, logic [31:0] exp, logic [31:0] act);
        checks++;
        assert (act === exp)
        else
        begin
            errors++;
            $display("MISMATCH %s %s: expected 0x%h, actual 0x%h", cur_test, field, exp, act);
        end
    endtask

    task automatic abort_on_timeout(string what);
        $display("%s: timed out waiting for %s", cur_test, what);
        $display("CHECKS FAILED");
        $finish;
    endtask

    task automatic fetch_start(logic [31:0] ins, logic [31:0] pc);
        @(negedge clk_i);
        instr_i = ins;
        pc_i    = pc;
        req_i   = 1'b1;
    endtask

    task automatic fetch_finish();
        int n;
        n = 0;
        do
        begin
            @(negedge clk_i);
            n++;
            if (n > TIMEOUT)
                abort_on_timeout("ack_o to rise");
        end
        while (!ack_o);
        req_i = 1'b0;
        n = 0;
        while (ack_o)
        begin
            @(negedge clk_i);
            n++;
            if (n > TIMEOUT)
                abort_on_timeout("ack_o to fall");
        end
    endtask

    task automatic exec_wait();
        int n;
        n = 0;
        while (!out_req_o)
        begin
            @(negedge clk_i);
            n++;
            if (n > TIMEOUT)
                abort_on_timeout("out_req_o to rise");
        end
    endtask

    task automatic exec_release();
        int n;
        n = 0;
        out_ack_i = 1'b1;
        while (out_req_o)
        begin
            @(negedge clk_i);
            n++;
            if (n > TIMEOUT)
                abort_on_timeout("out_req_o to fall");
        end
        out_ack_i = 1'b0;
    endtask

    task automatic check_record(logic [31:0] ins, logic [31:0] pc, logic [31:0] imm);
        logic [6:0]          opc;
        logic [2:0]          f3;
        logic [3:0]          fn;
        logic [2:0]          bsel;
        logic [2:0]          memw;
        logic                we;
        logic                use_imm;
        logic                save;
        logic                load;
        logic                ill;
        logic [4:0]          rs1;
        logic [CW_WIDTH-1:0] ctrl;
        opc     = ins[6:0];
        f3      = ins[14:12];
        fn      = FN_ADD;
        bsel    = BR_NONE;
        memw    = 3'd0;
        we      = 1'b0;
        use_imm = 1'b0;
        save    = 1'b0;
        load    = 1'b0;
        ill     = 1'b0;
        rs1     = ins[19:15];
        case (opc)
            OPC_OP:     {we, fn} = {1'b1, alu_fn(f3, ins[30], 1'b1)};
            OPC_OP_IMM: {we, use_imm, fn} = {2'b11, alu_fn(f3, ins[30], 1'b0)};
            OPC_LOAD:   {we, use_imm, load, memw} = {3'b111, f3};
            OPC_JALR:   {we, use_imm, save, bsel} = {3'b111, BR_JALR};
            OPC_STORE:  {use_imm, memw} = {1'b1, f3};
            OPC_BRANCH: {bsel, fn} = {br_code(f3), (f3 >= 3'd6) ? FN_SLTU : FN_SUB};
            OPC_LUI:    {we, use_imm, rs1} = {2'b11, 5'd0};
            OPC_AUIPC:  {we, use_imm, save, rs1} = {3'b111, 5'd0};
            OPC_JAL:    {we, use_imm, save, bsel, rs1} = {3'b111, BR_JAL, 5'd0};
            default:    ill = 1'b1;
        endcase
        ctrl = '0;
        if (!ill)
        begin
            ctrl[CW_RD_LSB +: 5]   = we ? ins[11:7] : 5'd0;
            ctrl[CW_RS2_LSB +: 5]  = ins[24:20];
            ctrl[CW_RS1_LSB +: 5]  = rs1;
            ctrl[CW_FN_LSB +: 4]   = fn;
            ctrl[CW_WE]            = we;
            ctrl[CW_SAVE_PC]       = save;
            ctrl[CW_LOAD]          = load;
            ctrl[CW_USE_IMM]       = use_imm;
            ctrl[CW_MEMW_LSB +: 3] = memw;
        end
        check_val("ctrl", 32'(ctrl), 32'(ctrl_o));
        check_val("branch_sel", 32'(bsel), 32'(branch_sel_o));
        check_val("imm", imm, imm_o);
        check_val("illegal", 32'(ill), 32'(illegal_o));
        check_val("link", pc + 32'd4, link_o);
        check_val("target", pc + imm, target_o);
        check_val("trace_pc", pc, trace_pc_o);
        check_val("trace_instr", ins, trace_instr_o);
    endtask

    task automatic run_case(logic [31:0] ins, logic [31:0] pc, logic [31:0] imm);
        fetch_start(ins, pc);
        fetch_finish();
        exec_wait();
        check_record(ins, pc, imm);
        exec_release();
    endtask

    task automatic test_reset();
        logic [31:0] ins;
        logic [31:0] pc;
        begin_test("reset");
        check_val("ack_o", 32'd0, 32'(ack_o));
        check_val("out_req_o", 32'd0, 32'(out_req_o));
        check_val("illegal_o", 32'd0, 32'(illegal_o));
        check_val("record", 32'd0, 32'(|{ctrl_o, branch_sel_o, imm_o, link_o, target_o,
                                         trace_pc_o, trace_instr_o}));
        ins = enc_i(12'h07b, 3'd0, OPC_OP_IMM);
        pc  = rnd_pc();
        fetch_start(ins, pc);
        @(negedge clk_i);  // One cycle after req_i
        check_val("ack_o after 1 cycle", 32'd1, 32'(ack_o));
        check_val("out_req_o after 1 cycle", 32'd1, 32'(out_req_o));
        fetch_finish();
        exec_wait();
        check_record(ins, pc, 32'h7b);
        exec_release();
        end_test();
    endtask

    task automatic test_alu();
        logic [11:0] imm12;
        begin_test("alu");
        for (int f3 = 0; f3 < 8; f3++)
        begin
            for (int alt = 0; alt < 2; alt++)
            begin
                run_case(enc_r((alt != 0) ? 7'b0100000 : 7'b0000000, 3'(f3)), rnd_pc(), 32'd0);
                imm12 = 12'($urandom);
                if (f3 == 1 || f3 == 5)
                    imm12 = {1'b0, 1'(alt), 5'd0, imm12[4:0]};  // Shift amount form
                run_case(enc_i(imm12, 3'(f3), OPC_OP_IMM), rnd_pc(), sext(32'(imm12), 12));
            end
        end
        end_test();
    endtask

    task automatic test_mem();
        logic [11:0] imm12;
        begin_test("load_store");
        for (int f3 = 0; f3 < 6; f3++)
        begin
            imm12 = 12'($urandom);
            if (f3 != 3)
                run_case(enc_i(imm12, 3'(f3), OPC_LOAD), rnd_pc(), sext(32'(imm12), 12));
            imm12 = 12'($urandom);
            if (f3 < 3)
                run_case(enc_s(imm12, 3'(f3)), rnd_pc(), sext(32'(imm12), 12));
        end
        end_test();
    endtask

    task automatic test_branch();
        logic [12:0] imm13;
        begin_test("branch");
        for (int f3 = 0; f3 < 8; f3++)
        begin
            imm13 = 13'($urandom) & 13'h1ffe;
            if (f3 != 2 && f3 != 3)
                run_case(enc_b(imm13, 3'(f3)), rnd_pc(), sext(32'(imm13), 13));
        end
        end_test();
    endtask

    task automatic test_jump_upper();
        logic [20:0] imm21;
        logic [11:0] imm12;
        logic [19:0] imm20;
        begin_test("jump_upper");
        imm21 = 21'($urandom) & 21'h1ffffe;
        run_case(enc_j(imm21), rnd_pc(), sext(32'(imm21), 21));
        imm12 = 12'($urandom);
        run_case(enc_i(imm12, 3'd0, OPC_JALR), rnd_pc(), sext(32'(imm12), 12));
        imm20 = 20'($urandom);
        run_case({imm20, rnd_reg(), OPC_LUI}, rnd_pc(), {imm20, 12'd0});
        imm20 = 20'($urandom);
        run_case({imm20, rnd_reg(), OPC_AUIPC}, rnd_pc(), {imm20, 12'd0});
        run_case({25'($urandom), 7'b1111111}, rnd_pc(), 32'd0);  // Unknown opcode
        end_test();
    endtask

    task automatic test_backpressure();
        logic [31:0] ins_a;
        logic [31:0] ins_b;
        logic [31:0] pc_a;
        logic [31:0] pc_b;
        begin_test("backpressure");
        ins_a = enc_i(12'h800, 3'd2, OPC_LOAD);
        ins_b = enc_r(7'b0100000, 3'd0);
        pc_a  = rnd_pc();
        pc_b  = rnd_pc();
        fetch_start(ins_a, pc_a);
        fetch_finish();
        fetch_start(ins_b, pc_b);  // Slot still held by A
        for (int i = 0; i < 8; i++)
        begin
            @(negedge clk_i);
            checks++;
            assert (!ack_o)
            else
            begin
                errors++;
                $display("%s: ack_o rose while the output slot was occupied", cur_test);
            end
        end
        check_record(ins_a, pc_a, 32'hffff_f800);
        exec_release();
        fetch_finish();
        exec_wait();
        check_record(ins_b, pc_b, 32'd0);
        exec_release();
        end_test();
    endtask

    initial
    begin
        void'($urandom(32'h52e3));
        arst_n_i  = 1'b0;
        req_i     = 1'b0;
        pc_i      = 32'd0;
        instr_i   = 32'd0;
        out_ack_i = 1'b0;
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;

        test_reset();
        test_alu();
        test_mem();
        test_branch();
        test_jump_upper();
        test_backpressure();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: rtl/rv32i_decode_top.sv
`timescale 1ns/1ps

module rv32i_decode_top (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  logic                           req_i,
    output logic                           ack_o,
    input  logic [31:0]                    pc_i,
    input  logic [31:0]                    instr_i,
    output logic                           out_req_o,
    input  logic                           out_ack_i,
    output logic [rv32i_pkg::CW_WIDTH-1:0] ctrl_o,
    output logic [2:0]                     branch_sel_o,
    output logic [31:0]                    imm_o,
    output logic                           illegal_o,
    output logic [31:0]                    link_o,
    output logic [31:0]                    target_o,
    output logic [31:0]                    trace_pc_o,
    output logic [31:0]                    trace_instr_o
);

    import rv32i_pkg::*;

    logic [CW_WIDTH-1:0] dec_ctrl;
    logic [2:0]          dec_branch_sel;
    logic                dec_illegal;
    logic [31:0]         dec_imm;

    rv32i_decoder u_decoder (
        .instr_i      (instr_i),
        .ctrl_o       (dec_ctrl),
        .branch_sel_o (dec_branch_sel),
        .illegal_o    (dec_illegal)
    );

    rv32i_imm_gen u_imm_gen (
        .instr_i (instr_i),
        .imm_o   (dec_imm)
    );

    rv32i_decode_stage u_stage (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .req_i         (req_i),
        .ack_o         (ack_o),
        .pc_i          (pc_i),
        .instr_i       (instr_i),
        .ctrl_i        (dec_ctrl),
        .branch_sel_i  (dec_branch_sel),
        .illegal_i     (dec_illegal),
        .imm_i         (dec_imm),
        .out_req_o     (out_req_o),
        .out_ack_i     (out_ack_i),
        .ctrl_o        (ctrl_o),
        .branch_sel_o  (branch_sel_o),
        .imm_o         (imm_o),
        .illegal_o     (illegal_o),
        .link_o        (link_o),
        .target_o      (target_o),
        .trace_pc_o    (trace_pc_o),
        .trace_instr_o (trace_instr_o)
    );

endmodule

// File: rtl/rv32i_decode_stage.sv
`timescale 1ns/1ps

module rv32i_decode_stage (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  logic                           req_i,
    output logic                           ack_o,
    input  logic [31:0]                    pc_i,
    input  logic [31:0]                    instr_i,
    input  logic [rv32i_pkg::CW_WIDTH-1:0] ctrl_i,
    input  logic [2:0]                     branch_sel_i,
    input  logic                           illegal_i,
    input  logic [31:0]                    imm_i,
    output logic                           out_req_o,
    input  logic                           out_ack_i,
    output logic [rv32i_pkg::CW_WIDTH-1:0] ctrl_o,
    output logic [2:0]                     branch_sel_o,
    output logic [31:0]                    imm_o,
    output logic                           illegal_o,
    output logic [31:0]                    link_o,
    output logic [31:0]                    target_o,
    output logic [31:0]                    trace_pc_o,
    output logic [31:0]                    trace_instr_o
);

    logic slot_free;  // Output record may be overwritten
    logic capture;

    assign capture = req_i & ~ack_o & slot_free;

    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            ack_o     <= 1'b0;
            out_req_o <= 1'b0;
            slot_free <= 1'b1;
        end
        else
        begin
            if (capture)
                ack_o <= 1'b1;
            else if (!req_i)
                ack_o <= 1'b0;  // Fetch released its request

            if (capture)
                out_req_o <= 1'b1;
            else if (out_ack_i)
                out_req_o <= 1'b0;

            // Free only after execute has completed its four phases
            if (capture)
                slot_free <= 1'b0;
            else if (!out_req_o && !out_ack_i)
                slot_free <= 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            ctrl_o        <= '0;
            branch_sel_o  <= '0;
            imm_o         <= '0;
            illegal_o     <= 1'b0;
            link_o        <= '0;
            target_o      <= '0;
            trace_pc_o    <= '0;
            trace_instr_o <= '0;
        end
        else if (capture)
        begin
            ctrl_o        <= ctrl_i;
            branch_sel_o  <= branch_sel_i;
            imm_o         <= imm_i;
            illegal_o     <= illegal_i;
            link_o        <= pc_i + 32'd4;  // Return address for JAL, JALR
            target_o      <= pc_i + imm_i;  // Branch, JAL and AUIPC result
            trace_pc_o    <= pc_i;
            trace_instr_o <= instr_i;
        end
    end

    out_req_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        out_req_o && !out_ack_i |=> out_req_o);

    record_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        out_req_o |=> $stable({ctrl_o, branch_sel_o, imm_o, illegal_o,
                               link_o, target_o, trace_pc_o, trace_instr_o}));

endmodule

// File: rtl/rv32i_imm_gen.sv
`timescale 1ns/1ps

module rv32i_imm_gen (
    input  logic [31:0] instr_i,
    output logic [31:0] imm_o
);

    import rv32i_pkg::*;

    logic [31:0] imm_i_fmt;
    logic [31:0] imm_s_fmt;
    logic [31:0] imm_b_fmt;
    logic [31:0] imm_u_fmt;
    logic [31:0] imm_j_fmt;

    assign imm_i_fmt = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s_fmt = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};

    // B and J offsets are in half-words, bit 0 is always zero
    assign imm_b_fmt = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                        instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_j_fmt = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                        instr_i[20], instr_i[30:21], 1'b0};

    assign imm_u_fmt = {instr_i[31:12], 12'd0};  // Upper 20 bits

    always_comb
    begin
        case (instr_i[6:0])
            OPC_OP_IMM,
            OPC_LOAD,
            OPC_JALR:
                imm_o = imm_i_fmt;
            OPC_STORE:
                imm_o = imm_s_fmt;
            OPC_BRANCH:
                imm_o = imm_b_fmt;
            OPC_LUI,
            OPC_AUIPC:
                imm_o = imm_u_fmt;
            OPC_JAL:
                imm_o = imm_j_fmt;
            default:
                imm_o = 32'd0;  // R-type and unknown
        endcase
    end

endmodule

// File: rtl/rv32i_decoder.sv
`timescale 1ns/1ps

module rv32i_decoder (
    input  logic [31:0]                    instr_i,
    output logic [rv32i_pkg::CW_WIDTH-1:0] ctrl_o,
    output logic [2:0]                     branch_sel_o,
    output logic                           illegal_o
);

    import rv32i_pkg::*;

    logic       r_type;
    logic       i_type;
    logic       s_type;
    logic       b_type;
    logic       u_type;
    logic       j_type;
    logic       load;       // Load instruction
    logic       jalr;
    logic       save_pc;    // JAL, JALR and AUIPC

    logic [2:0] funct3;
    logic       use_imm;
    logic       we;         // Register file write enable
    logic [3:0] fn_sel;
    logic [2:0] mem_width;
    logic [4:0] rd_addr;
    logic [4:0] rs1_addr;
    logic [4:0] rs2_addr;

    assign funct3 = instr_i[14:12];

    assign use_imm   = i_type | s_type | u_type | j_type;
    assign we        = r_type | i_type | u_type | j_type;
    assign rd_addr   = we ? instr_i[11:7] : 5'd0;
    assign rs1_addr  = (u_type | j_type | illegal_o) ? 5'd0 : instr_i[19:15];
    assign rs2_addr  = illegal_o ? 5'd0 : instr_i[24:20];
    assign mem_width = (s_type | load) ? funct3 : 3'd0;

    always_comb
    begin
        r_type    = 1'b0;
        i_type    = 1'b0;
        s_type    = 1'b0;
        b_type    = 1'b0;
        u_type    = 1'b0;
        j_type    = 1'b0;
        load      = 1'b0;
        jalr      = 1'b0;
        save_pc   = 1'b0;
        illegal_o = 1'b0;
        case (instr_i[6:0])
            OPC_OP:     r_type = 1'b1;
            OPC_OP_IMM: i_type = 1'b1;
            OPC_LOAD:
            begin
                i_type = 1'b1;
                load   = 1'b1;
            end
            OPC_JALR:
            begin
                i_type  = 1'b1;
                jalr    = 1'b1;
                save_pc = 1'b1;
            end
            OPC_STORE:  s_type = 1'b1;
            OPC_BRANCH: b_type = 1'b1;
            OPC_LUI:    u_type = 1'b1;
            OPC_AUIPC:
            begin
                u_type  = 1'b1;
                save_pc = 1'b1;  // rd gets PC plus imm
            end
            OPC_JAL:
            begin
                j_type  = 1'b1;
                save_pc = 1'b1;
            end
            default:    illegal_o = 1'b1;
        endcase
    end

    always_comb
    begin
        branch_sel_o = BR_NONE;
        if (jalr)
            branch_sel_o = BR_JALR;
        else if (j_type)
            branch_sel_o = BR_JAL;
        else if (b_type)
        begin
            case (funct3)
                3'b000:  branch_sel_o = BR_EQ;
                3'b001:  branch_sel_o = BR_NE;
                3'b100:  branch_sel_o = BR_LT;
                3'b101:  branch_sel_o = BR_GE;
                3'b110:  branch_sel_o = BR_LT;  // BLTU, unsigned via FN_SLTU
                3'b111:  branch_sel_o = BR_GE;  // BGEU
                default: branch_sel_o = BR_NONE;
            endcase
        end
    end

    always_comb
    begin
        fn_sel = FN_ADD;  // Loads, stores, jumps, upper imm
        if ((r_type | i_type) & ~load & ~jalr)
        begin
            case (funct3)
                3'b000:  fn_sel = (r_type & instr_i[30]) ? FN_SUB : FN_ADD;
                3'b001:  fn_sel = FN_SLL;
                3'b010:  fn_sel = FN_SLT;
                3'b011:  fn_sel = FN_SLTU;
                3'b100:  fn_sel = FN_XOR;
                3'b101:  fn_sel = instr_i[30] ? FN_SRA : FN_SRL;
                3'b110:  fn_sel = FN_OR;
                default: fn_sel = FN_AND;
            endcase
        end
        else if (b_type)
            fn_sel = (funct3[2:1] == 2'b11) ? FN_SLTU : FN_SUB;
    end

    always_comb
    begin
        ctrl_o                    = '0;
        ctrl_o[CW_RD_LSB +: 5]    = rd_addr;
        ctrl_o[CW_RS2_LSB +: 5]   = rs2_addr;
        ctrl_o[CW_RS1_LSB +: 5]   = rs1_addr;
        ctrl_o[CW_FN_LSB +: 4]    = fn_sel;
        ctrl_o[CW_WE]             = we;
        ctrl_o[CW_SAVE_PC]        = save_pc;
        ctrl_o[CW_LOAD]           = load;
        ctrl_o[CW_USE_IMM]        = use_imm;
        ctrl_o[CW_MEMW_LSB +: 3]  = mem_width;
    end

endmodule

// File: rtl/rv32i_pkg.sv
package rv32i_pkg;

    // Major opcodes accepted by the decoder
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // Branch select codes
    localparam logic [2:0] BR_NONE = 3'd0;
    localparam logic [2:0] BR_EQ   = 3'd2;
    localparam logic [2:0] BR_NE   = 3'd3;
    localparam logic [2:0] BR_LT   = 3'd4;  // Also BLTU
    localparam logic [2:0] BR_GE   = 3'd5;  // Also BGEU
    localparam logic [2:0] BR_JAL  = 3'd6;
    localparam logic [2:0] BR_JALR = 3'd7;

    // ALU function codes
    localparam logic [3:0] FN_ADD  = 4'd0;
    localparam logic [3:0] FN_SUB  = 4'd1;
    localparam logic [3:0] FN_SLT  = 4'd2;
    localparam logic [3:0] FN_SLTU = 4'd3;
    localparam logic [3:0] FN_XOR  = 4'd4;
    localparam logic [3:0] FN_OR   = 4'd5;
    localparam logic [3:0] FN_AND  = 4'd6;
    localparam logic [3:0] FN_SLL  = 4'd8;
    localparam logic [3:0] FN_SRA  = 4'd9;
    localparam logic [3:0] FN_SRL  = 4'd10;

    // Control word layout
    localparam int CW_WIDTH    = 26;
    localparam int CW_RD_LSB   = 21;  // 25:21
    localparam int CW_RS2_LSB  = 16;  // 20:16
    localparam int CW_RS1_LSB  = 11;  // 15:11
    localparam int CW_FN_LSB   = 7;   // 10:7
    localparam int CW_WE       = 6;
    localparam int CW_SAVE_PC  = 5;
    localparam int CW_LOAD     = 4;
    localparam int CW_USE_IMM  = 3;
    localparam int CW_MEMW_LSB = 0;   // 2:0, funct3 of load or store

endpackage
